/* include/lsu_settings.svh */
// ----------------------------------------------------------
// LSU settings
// Data, address and tag widths, store queue and memory depth
// ----------------------------------------------------------

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// Word and byte address
`define DATA_WIDTH 32
`define ADDR_WIDTH 32

// Reorder buffer tag
`define TAG_WIDTH  6

// Store queue entries and data memory words
`define SQ_DEPTH   4
`define DC_DEPTH   64

`endif

/* verilog/lsu_pkg.sv */
// ----------------------------------------------------------
// LSU package
// Payload types and the opcode and function encodings
// ----------------------------------------------------------

`include "lsu_settings.svh"

package lsu_pkg;

    typedef logic [`DATA_WIDTH-1:0] lsu_data_t;
    typedef logic [`ADDR_WIDTH-1:0] lsu_addr_t;
    typedef logic [`TAG_WIDTH-1:0]  lsu_tag_t;

    // Class of the operation issued to the LSU
    typedef enum logic {
        OPCODE_LOAD  = 1'b0,
        OPCODE_STORE = 1'b1
    } lsu_opcode_t;

    // MSB marks a store, low bits follow funct3
    typedef enum logic [3:0] {
        LSU_FUNC_LB  = 4'b0000,
        LSU_FUNC_LH  = 4'b0001,
        LSU_FUNC_LW  = 4'b0010,
        LSU_FUNC_LBU = 4'b0100,
        LSU_FUNC_LHU = 4'b0101,
        LSU_FUNC_SB  = 4'b1000,
        LSU_FUNC_SH  = 4'b1001,
        LSU_FUNC_SW  = 4'b1010
    } lsu_func_t;

endpackage

/* verilog/lsu_if.sv */
// ----------------------------------------------------------
// LSU interfaces
// Store allocation and data memory write
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

interface lsu_alloc_if;
    logic               en;
    lsu_pkg::lsu_func_t func;
    lsu_pkg::lsu_tag_t  tag;
    lsu_pkg::lsu_addr_t addr;
    lsu_pkg::lsu_data_t data;

    modport id (output en, output func, output tag, output addr, output data);
    modport sq (input en, input func, input tag, input addr, input data);
endinterface

interface lsu_wr_if;
    logic                       en;
    lsu_pkg::lsu_addr_t         addr;
    logic [`DATA_WIDTH/8-1:0]   byte_en;
    // Already placed in its byte lanes
    lsu_pkg::lsu_data_t         data;

    modport sq (output en, output addr, output byte_en, output data);
    modport ram (input en, input addr, input byte_en, input data);
endinterface

/* verilog/lsu_id.sv */
// ----------------------------------------------------------
// LSU ID stage
// Function decode, address generation and store allocation
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_id (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,
    input  logic                 i_valid,
    input  logic                 i_stall,
    input  lsu_pkg::lsu_opcode_t i_opcode,
    input  lsu_pkg::lsu_data_t   i_insn,
    input  lsu_pkg::lsu_data_t   i_src_a,
    input  lsu_pkg::lsu_data_t   i_src_b,
    input  lsu_pkg::lsu_tag_t    i_tag,
    output lsu_pkg::lsu_func_t   o_func,
    output lsu_pkg::lsu_addr_t   o_addr,
    output lsu_pkg::lsu_tag_t    o_tag,
    output logic                 o_valid,
    lsu_alloc_if.id              alloc
);

    lsu_pkg::lsu_func_t func;
    lsu_pkg::lsu_data_t imm;
    lsu_pkg::lsu_addr_t addr;
    logic               is_store;
    logic               accept;

    assign is_store = (i_opcode == lsu_pkg::OPCODE_STORE);
    assign accept   = i_valid && !i_stall;

    always_comb begin
        if (is_store) begin
            case (i_insn[13:12])
                2'b00:   func = lsu_pkg::LSU_FUNC_SB;
                2'b01:   func = lsu_pkg::LSU_FUNC_SH;
                default: func = lsu_pkg::LSU_FUNC_SW;
            endcase
        end else begin
            case (i_insn[14:12])
                3'b000:  func = lsu_pkg::LSU_FUNC_LB;
                3'b001:  func = lsu_pkg::LSU_FUNC_LH;
                3'b100:  func = lsu_pkg::LSU_FUNC_LBU;
                3'b101:  func = lsu_pkg::LSU_FUNC_LHU;
                default: func = lsu_pkg::LSU_FUNC_LW;
            endcase
        end
    end

    // S-type splits the immediate around rd
    assign imm = is_store ? {{(`DATA_WIDTH-12){i_insn[31]}}, i_insn[31:25], i_insn[11:7]}
                          : {{(`DATA_WIDTH-12){i_insn[31]}}, i_insn[31:20]};
    assign addr = i_src_a + imm;

    always_ff @(posedge clk) begin
        o_func <= func;
        o_addr <= addr;
        o_tag  <= i_tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else if (i_flush) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= accept;
        end
    end

    assign alloc.en   = accept && is_store;
    assign alloc.func = func;
    assign alloc.tag  = i_tag;
    assign alloc.addr = addr;
    assign alloc.data = i_src_b;

endmodule

/* verilog/lsu_ex.sv */
// ----------------------------------------------------------
// LSU EX stage
// Memory read, load extension and bus output register
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_ex (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,
    input  lsu_pkg::lsu_func_t i_func,
    input  lsu_pkg::lsu_addr_t i_addr,
    input  lsu_pkg::lsu_tag_t  i_tag,
    input  logic               i_valid,
    input  lsu_pkg::lsu_data_t i_rd_data,
    output lsu_pkg::lsu_addr_t o_rd_addr,
    output logic               o_cdb_en,
    output lsu_pkg::lsu_data_t o_cdb_data,
    output lsu_pkg::lsu_addr_t o_cdb_addr,
    output lsu_pkg::lsu_tag_t  o_cdb_tag
);

    lsu_pkg::lsu_data_t shifted;
    lsu_pkg::lsu_data_t ex_data;

    assign o_rd_addr = {i_addr[`ADDR_WIDTH-1:2], 2'b00};

    // Bring the addressed byte or halfword down to bit 0
    assign shifted = i_rd_data >> {i_addr[1:0], 3'b000};

    always_comb begin
        case (i_func)
            lsu_pkg::LSU_FUNC_LB:  ex_data = {{(`DATA_WIDTH-8){shifted[7]}}, shifted[7:0]};
            lsu_pkg::LSU_FUNC_LBU: ex_data = {{(`DATA_WIDTH-8){1'b0}}, shifted[7:0]};
            lsu_pkg::LSU_FUNC_LH:  ex_data = {{(`DATA_WIDTH-16){shifted[15]}}, shifted[15:0]};
            lsu_pkg::LSU_FUNC_LHU: ex_data = {{(`DATA_WIDTH-16){1'b0}}, shifted[15:0]};
            lsu_pkg::LSU_FUNC_LW:  ex_data = shifted;
            // Stores only report completion
            default:               ex_data = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        o_cdb_data <= ex_data;
        o_cdb_addr <= i_addr;
        o_cdb_tag  <= i_tag;
    end

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_cdb_en <= 1'b0;
        end else if (i_flush) begin
            o_cdb_en <= 1'b0;
        end else begin
            o_cdb_en <= i_valid;
        end
    end

endmodule

/* verilog/lsu_sq_entry.sv */
// ----------------------------------------------------------
// Store queue entry
// Holds one store until it is retired or flushed
// ----------------------------------------------------------

`timescale 1ns/1ps

module lsu_sq_entry (
    input  logic               clk,
    input  logic               n_rst,
    input  logic               i_flush,
    input  logic               i_alloc_en,
    input  logic               i_free,
    input  lsu_pkg::lsu_tag_t  i_retire_tag,
    lsu_alloc_if.sq            alloc,
    output logic               o_valid,
    output logic               o_match,
    output lsu_pkg::lsu_func_t o_func,
    output lsu_pkg::lsu_addr_t o_addr,
    output lsu_pkg::lsu_data_t o_data
);

    lsu_pkg::lsu_tag_t tag;

    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            o_func <= alloc.func;
            o_addr <= alloc.addr;
            o_data <= alloc.data;
            tag    <= alloc.tag;
        end
    end

    // Flush wins over a store allocated in the same cycle
    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            o_valid <= 1'b0;
        end else if (i_flush || i_free) begin
            o_valid <= 1'b0;
        end else if (i_alloc_en) begin
            o_valid <= 1'b1;
        end
    end

    assign o_match = o_valid && (tag == i_retire_tag);

endmodule

/* verilog/lsu_sq.sv */
// ----------------------------------------------------------
// Store queue
// Allocates stores and drains them to memory on retire
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_sq #(
    parameter int SQ_DEPTH = `SQ_DEPTH
) (
    input  logic              clk,
    input  logic              n_rst,
    input  logic              i_flush,
    input  logic              i_rob_retire_en,
    input  lsu_pkg::lsu_tag_t i_rob_retire_tag,
    output logic              o_full,
    output logic              o_rob_retire_stall,
    lsu_alloc_if.sq           alloc,
    lsu_wr_if.sq              wr
);

    localparam int IDX_W = (SQ_DEPTH > 1) ? $clog2(SQ_DEPTH) : 1;
    localparam int BE_W  = `DATA_WIDTH / 8;

    logic [SQ_DEPTH-1:0] entry_valid;
    logic [SQ_DEPTH-1:0] entry_match;
    logic [SQ_DEPTH-1:0] alloc_sel;
    lsu_pkg::lsu_func_t  entry_func [SQ_DEPTH];
    lsu_pkg::lsu_addr_t  entry_addr [SQ_DEPTH];
    lsu_pkg::lsu_data_t  entry_data [SQ_DEPTH];
    logic [IDX_W-1:0]    ret_idx;
    logic                ret_hit;
    lsu_pkg::lsu_func_t  ret_func;
    lsu_pkg::lsu_addr_t  ret_addr;
    logic [BE_W-1:0]     ret_be;

    // Lowest free slot takes the next store
    always_comb begin
        alloc_sel = '0;
        for (int i = SQ_DEPTH - 1; i >= 0; i--) begin
            if (!entry_valid[i]) begin
                alloc_sel    = '0;
                alloc_sel[i] = 1'b1;
            end
        end
    end

    assign o_full = &entry_valid;

    // Tags are unique, lowest match is taken anyway
    always_comb begin
        ret_idx = '0;
        for (int i = SQ_DEPTH - 1; i >= 0; i--) begin
            if (entry_match[i]) begin
                ret_idx = IDX_W'(i);
            end
        end
    end

    assign ret_hit            = i_rob_retire_en && (|entry_match);
    assign o_rob_retire_stall = i_rob_retire_en && !(|entry_match);

    assign ret_func = entry_func[ret_idx];
    assign ret_addr = entry_addr[ret_idx];

    always_comb begin
        case (ret_func)
            lsu_pkg::LSU_FUNC_SB: ret_be = BE_W'(1);
            lsu_pkg::LSU_FUNC_SH: ret_be = BE_W'(3);
            default:              ret_be = '1;
        endcase
    end

    assign wr.en      = ret_hit;
    assign wr.addr    = ret_addr;
    assign wr.byte_en = ret_be << ret_addr[1:0];
    assign wr.data    = entry_data[ret_idx] << {ret_addr[1:0], 3'b000};

    for (genvar g = 0; g < SQ_DEPTH; g++) begin : g_entry
        lsu_sq_entry u_entry (
            .clk          (clk),
            .n_rst        (n_rst),
            .i_flush      (i_flush),
            .i_alloc_en   (alloc.en && alloc_sel[g]),
            .i_free       (ret_hit && (ret_idx == IDX_W'(g))),
            .i_retire_tag (i_rob_retire_tag),
            .alloc        (alloc),
            .o_valid      (entry_valid[g]),
            .o_match      (entry_match[g]),
            .o_func       (entry_func[g]),
            .o_addr       (entry_addr[g]),
            .o_data       (entry_data[g])
        );
    end

endmodule

/* verilog/lsu_dc_ram.sv */
// ----------------------------------------------------------
// Data memory
// Word array, byte-lane write and combinational read
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_dc_ram #(
    parameter int DC_DEPTH = `DC_DEPTH
) (
    input  logic               clk,
    input  logic               n_rst,
    input  lsu_pkg::lsu_addr_t i_rd_addr,
    output lsu_pkg::lsu_data_t o_rd_data,
    lsu_wr_if.ram              wr
);

    localparam int AW   = (DC_DEPTH > 1) ? $clog2(DC_DEPTH) : 1;
    localparam int BE_W = `DATA_WIDTH / 8;

    lsu_pkg::lsu_data_t mem [DC_DEPTH];
    logic [AW-1:0]      rd_idx;
    logic [AW-1:0]      wr_idx;

    // Byte addresses, so skip the lane bits
    assign rd_idx = i_rd_addr[AW+1:2];
    assign wr_idx = wr.addr[AW+1:2];

    assign o_rd_data = mem[rd_idx];

    always_ff @(posedge clk, negedge n_rst) begin
        if (!n_rst) begin
            for (int i = 0; i < DC_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (wr.en) begin
            for (int b = 0; b < BE_W; b++) begin
                if (wr.byte_en[b]) begin
                    mem[wr_idx][8*b +: 8] <= wr.data[8*b +: 8];
                end
            end
        end
    end

endmodule

/* verilog/lsu.sv */
// ----------------------------------------------------------
// Load/store unit
// ID and EX stages, store queue and data memory
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu (
    input  logic                 clk,
    input  logic                 n_rst,
    input  logic                 i_flush,

    // Function unit issue
    input  logic                 i_fu_valid,
    input  lsu_pkg::lsu_opcode_t i_fu_opcode,
    input  lsu_pkg::lsu_data_t   i_fu_insn,
    input  lsu_pkg::lsu_data_t   i_fu_src_a,
    input  lsu_pkg::lsu_data_t   i_fu_src_b,
    input  lsu_pkg::lsu_tag_t    i_fu_tag,
    output logic                 o_fu_stall,

    // Reorder buffer retire
    input  logic                 i_rob_retire_en,
    input  lsu_pkg::lsu_tag_t    i_rob_retire_tag,
    output logic                 o_rob_retire_stall,

    // Common data bus
    output logic                 o_cdb_en,
    output lsu_pkg::lsu_data_t   o_cdb_data,
    output lsu_pkg::lsu_addr_t   o_cdb_addr,
    output lsu_pkg::lsu_tag_t    o_cdb_tag
);

    lsu_pkg::lsu_func_t id_func;
    lsu_pkg::lsu_addr_t id_addr;
    lsu_pkg::lsu_tag_t  id_tag;
    logic               id_valid;
    lsu_pkg::lsu_addr_t rd_addr;
    lsu_pkg::lsu_data_t rd_data;

    lsu_alloc_if u_alloc_if ();
    lsu_wr_if    u_wr_if ();

    lsu_id u_id (
        .clk      (clk),
        .n_rst    (n_rst),
        .i_flush  (i_flush),
        .i_valid  (i_fu_valid),
        .i_stall  (o_fu_stall),
        .i_opcode (i_fu_opcode),
        .i_insn   (i_fu_insn),
        .i_src_a  (i_fu_src_a),
        .i_src_b  (i_fu_src_b),
        .i_tag    (i_fu_tag),
        .o_func   (id_func),
        .o_addr   (id_addr),
        .o_tag    (id_tag),
        .o_valid  (id_valid),
        .alloc    (u_alloc_if.id)
    );

    lsu_ex u_ex (
        .clk        (clk),
        .n_rst      (n_rst),
        .i_flush    (i_flush),
        .i_func     (id_func),
        .i_addr     (id_addr),
        .i_tag      (id_tag),
        .i_valid    (id_valid),
        .i_rd_data  (rd_data),
        .o_rd_addr  (rd_addr),
        .o_cdb_en   (o_cdb_en),
        .o_cdb_data (o_cdb_data),
        .o_cdb_addr (o_cdb_addr),
        .o_cdb_tag  (o_cdb_tag)
    );

    lsu_sq #(
        .SQ_DEPTH (`SQ_DEPTH)
    ) u_sq (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_rob_retire_en    (i_rob_retire_en),
        .i_rob_retire_tag   (i_rob_retire_tag),
        .o_full             (o_fu_stall),
        .o_rob_retire_stall (o_rob_retire_stall),
        .alloc              (u_alloc_if.sq),
        .wr                 (u_wr_if.sq)
    );

    lsu_dc_ram #(
        .DC_DEPTH (`DC_DEPTH)
    ) u_dc_ram (
        .clk       (clk),
        .n_rst     (n_rst),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data),
        .wr        (u_wr_if.ram)
    );

endmodule

/* verification/lsu_sva.sv */
// ----------------------------------------------------------
// LSU assertions
// Reset, store allocation and retire checks
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_sva (
    input logic                 clk,
    input logic                 n_rst,
    input logic                 o_cdb_en,
    input logic                 alloc_en,
    input logic [`SQ_DEPTH-1:0] alloc_sel,
    input logic [`SQ_DEPTH-1:0] entry_valid,
    input logic [`SQ_DEPTH-1:0] entry_match,
    input logic                 i_rob_retire_en,
    input logic                 o_rob_retire_stall
);

    a_cdb_reset: assert property (@(posedge clk) !n_rst |-> !o_cdb_en)
        else $error("o_cdb_en high during reset");

    // Each store lands in exactly one free slot
    a_no_alloc_full: assert property (@(posedge clk) disable iff (!n_rst)
        alloc_en |-> $onehot(alloc_sel & ~entry_valid))
        else $error("store allocated without a free slot");

    // An accepted retire empties its slot at the write edge
    a_retire_frees: assert property (@(posedge clk) disable iff (!n_rst)
        (i_rob_retire_en && !o_rob_retire_stall)
            |=> ((entry_valid & $past(entry_match)) == '0))
        else $error("retired store still held in the queue");

endmodule

bind lsu lsu_sva u_lsu_sva (
    .clk                (clk),
    .n_rst              (n_rst),
    .o_cdb_en           (o_cdb_en),
    .alloc_en           (u_alloc_if.en),
    .alloc_sel          (u_sq.alloc_sel),
    .entry_valid        (u_sq.entry_valid),
    .entry_match        (u_sq.entry_match),
    .i_rob_retire_en    (i_rob_retire_en),
    .o_rob_retire_stall (o_rob_retire_stall)
);

/* verification/lsu_tb.sv */
// ----------------------------------------------------------
// LSU testbench
// Directed tests against a byte-wide reference memory
// ----------------------------------------------------------

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_tb;

    localparam int MAX_CYCLES = 3000;
    localparam int MEM_BYTES  = `DC_DEPTH * 4;

    logic                 clk;
    logic                 n_rst;
    logic                 i_flush;
    logic                 i_fu_valid;
    lsu_pkg::lsu_opcode_t i_fu_opcode;
    lsu_pkg::lsu_data_t   i_fu_insn;
    lsu_pkg::lsu_data_t   i_fu_src_a;
    lsu_pkg::lsu_data_t   i_fu_src_b;
    lsu_pkg::lsu_tag_t    i_fu_tag;
    logic                 o_fu_stall;
    logic                 i_rob_retire_en;
    lsu_pkg::lsu_tag_t    i_rob_retire_tag;
    logic                 o_rob_retire_stall;
    logic                 o_cdb_en;
    lsu_pkg::lsu_data_t   o_cdb_data;
    lsu_pkg::lsu_addr_t   o_cdb_addr;
    lsu_pkg::lsu_tag_t    o_cdb_tag;

    logic [7:0]  ref_mem [MEM_BYTES];
    logic [2:0]  st_f3 [64];
    logic [31:0] st_addr [64];
    logic [31:0] st_data [64];
    logic [31:0] lfsr = 32'he3e6f367;
    int          errors = 0;
    int          tests = 0;
    int          cycles = 0;
    logic [5:0]  next_tag = '0;

    lsu u_lsu (
        .clk                (clk),
        .n_rst              (n_rst),
        .i_flush            (i_flush),
        .i_fu_valid         (i_fu_valid),
        .i_fu_opcode        (i_fu_opcode),
        .i_fu_insn          (i_fu_insn),
        .i_fu_src_a         (i_fu_src_a),
        .i_fu_src_b         (i_fu_src_b),
        .i_fu_tag           (i_fu_tag),
        .o_fu_stall         (o_fu_stall),
        .i_rob_retire_en    (i_rob_retire_en),
        .i_rob_retire_tag   (i_rob_retire_tag),
        .o_rob_retire_stall (o_rob_retire_stall),
        .o_cdb_en           (o_cdb_en),
        .o_cdb_data         (o_cdb_data),
        .o_cdb_addr         (o_cdb_addr),
        .o_cdb_tag          (o_cdb_tag)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Result: FAILED");
            $finish;
        end
    end

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    function automatic logic [31:0] load_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm, 5'd1, f3, 5'd2, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_insn(input logic [2:0] f3, input logic [11:0] imm);
        return {imm[11:5], 5'd2, 5'd1, f3, imm[4:0], 7'b0100011};
    endfunction

    // Byte offset inside a word, aligned to the access size
    function automatic logic [1:0] lane_off(input logic [2:0] f3);
        logic [31:0] b;
        b = '0;
        if (f3[1:0] == 2'd0) begin
            b = rand_bits(2);
        end else if (f3[1:0] == 2'd1) begin
            b = rand_bits(1) << 1;
        end
        return b[1:0];
    endfunction

    function automatic logic [31:0] ref_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [7:0]  b0;
        logic [15:0] h;
        int          a;
        a  = addr % MEM_BYTES;
        b0 = ref_mem[a];
        h  = {ref_mem[(a + 1) % MEM_BYTES], b0};
        case (f3)
            3'd0:    return {{24{b0[7]}}, b0};
            3'd1:    return {{16{h[15]}}, h};
            3'd4:    return {24'd0, b0};
            3'd5:    return {16'd0, h};
            default: return {ref_mem[(a + 3) % MEM_BYTES], ref_mem[(a + 2) % MEM_BYTES], h};
        endcase
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int start_errors);
        tests++;
        $display("Test %s done with %0d errors", name, errors - start_errors);
    endtask

    // Returns at the falling edge right after the accepting edge
    task automatic issue(input lsu_pkg::lsu_opcode_t op, input logic [2:0] f3,
                         input logic [31:0] addr, input logic [5:0] tag,
                         input logic [31:0] data);
        logic [31:0] b;
        logic [11:0] imm;
        b   = rand_bits(5);
        imm = {{7{b[4]}}, b[4:0]};
        i_fu_opcode = op;
        i_fu_insn   = (op == lsu_pkg::OPCODE_STORE) ? store_insn(f3, imm) : load_insn(f3, imm);
        i_fu_src_a  = addr - {{20{imm[11]}}, imm};
        i_fu_src_b  = data;
        i_fu_tag    = tag;
        i_fu_valid  = 1'b1;
        while (o_fu_stall) begin
            @(negedge clk);
        end
        @(negedge clk);
        i_fu_valid = 1'b0;
    endtask

    task automatic expect_cdb(input logic [31:0] data, input logic [31:0] addr,
                              input logic [5:0] tag);
        @(negedge clk);
        check("o_cdb_en", 32'(o_cdb_en), 32'd1);
        check("o_cdb_data", o_cdb_data, data);
        check("o_cdb_addr", o_cdb_addr, addr);
        check("o_cdb_tag", 32'(o_cdb_tag), 32'(tag));
    endtask

    task automatic do_store(input logic [2:0] f3, input logic [31:0] addr,
                            input logic [31:0] data, input logic [5:0] tag);
        st_f3[tag]   = f3;
        st_addr[tag] = addr;
        st_data[tag] = data;
        issue(lsu_pkg::OPCODE_STORE, f3, addr, tag, data);
        expect_cdb(32'd0, addr, tag);
    endtask

    task automatic do_load(input logic [2:0] f3, input logic [31:0] addr);
        logic [31:0] exp;
        exp = ref_load(f3, addr);
        issue(lsu_pkg::OPCODE_LOAD, f3, addr, next_tag, rand_bits(32));
        expect_cdb(exp, addr, next_tag);
        next_tag++;
    endtask

    // Accepted retire, reference memory follows the write
    task automatic retire(input logic [5:0] tag);
        int n;
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        #1;
        check("o_rob_retire_stall", 32'(o_rob_retire_stall), 32'd0);
        @(negedge clk);
        i_rob_retire_en = 1'b0;
        n = (st_f3[tag] == 3'd0) ? 1 : (st_f3[tag] == 3'd1) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            ref_mem[(st_addr[tag] + i) % MEM_BYTES] = st_data[tag][8*i +: 8];
        end
    endtask

    task automatic retire_absent(input logic [5:0] tag);
        i_rob_retire_en  = 1'b1;
        i_rob_retire_tag = tag;
        #1;
        check("o_rob_retire_stall", 32'(o_rob_retire_stall), 32'd1);
        @(negedge clk);
        check("o_rob_retire_stall", 32'(o_rob_retire_stall), 32'd1);
        i_rob_retire_en = 1'b0;
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        check("o_fu_stall", 32'(o_fu_stall), 32'd0);
        for (int i = 0; i < 3; i++) begin
            do_load(3'd2, rand_bits(6) << 2);
        end
        @(negedge clk);
        check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        finish_test("reset", e0);
    endtask

    task automatic test_isolation();
        int          e0;
        logic [31:0] addr;
        e0   = errors;
        addr = 32'h40;
        do_store(3'd2, addr, rand_bits(32), next_tag);
        // Not retired yet, so the load sees the old word
        do_load(3'd2, addr);
        retire(next_tag - 6'd1);
        do_load(3'd2, addr);
        finish_test("store_isolation", e0);
    endtask

    task automatic test_widths();
        int          e0;
        logic [2:0]  f3;
        logic [5:0]  word;
        logic [2:0]  load_f3 [5];
        logic [5:0]  tag;
        e0      = errors;
        load_f3 = '{3'd0, 3'd4, 3'd1, 3'd5, 3'd2};
        for (int n = 0; n < 6; n++) begin
            f3   = 3'(rand_bits(2));
            f3   = (f3 > 3'd2) ? 3'd2 : f3;
            word = 6'(rand_bits(6));
            tag  = next_tag;
            next_tag++;
            do_store(f3, {word, lane_off(f3)}, rand_bits(32), tag);
            retire(tag);
            for (int k = 0; k < 5; k++) begin
                do_load(load_f3[k], {word, lane_off(load_f3[k])});
            end
        end
        finish_test("retire_widths", e0);
    endtask

    task automatic test_back_pressure();
        int         e0;
        logic [5:0] t0;
        e0 = errors;
        t0 = next_tag;
        next_tag += 6'd5;
        for (int i = 0; i < 4; i++) begin
            do_store(3'd2, 32'h80 + 4 * i, rand_bits(32), t0 + 6'(i));
        end
        check("o_fu_stall", 32'(o_fu_stall), 32'd1);
        // Fifth store stays on the inputs until a slot frees up
        st_f3[t0 + 6'd4]   = 3'd2;
        st_addr[t0 + 6'd4] = 32'h90;
        st_data[t0 + 6'd4] = rand_bits(32);
        i_fu_opcode = lsu_pkg::OPCODE_STORE;
        i_fu_insn   = store_insn(3'd2, 12'd0);
        i_fu_src_a  = 32'h90;
        i_fu_src_b  = st_data[t0 + 6'd4];
        i_fu_tag    = t0 + 6'd4;
        i_fu_valid  = 1'b1;
        for (int i = 0; i < 2; i++) begin
            @(negedge clk);
            check("o_fu_stall", 32'(o_fu_stall), 32'd1);
            check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        end
        retire_absent(t0 + 6'd8);
        check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        retire(t0);
        check("o_fu_stall", 32'(o_fu_stall), 32'd0);
        @(negedge clk);
        i_fu_valid = 1'b0;
        expect_cdb(32'd0, 32'h90, t0 + 6'd4);
        for (int i = 1; i < 5; i++) begin
            retire(t0 + 6'(i));
        end
        do_load(3'd2, 32'h90);
        finish_test("back_pressure", e0);
    endtask

    task automatic test_flush();
        int         e0;
        logic [5:0] t0;
        e0 = errors;
        issue(lsu_pkg::OPCODE_LOAD, 3'd2, 32'h40, next_tag, 32'd0);
        i_flush = 1'b1;
        @(negedge clk);
        check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        i_flush = 1'b0;
        @(negedge clk);
        check("o_cdb_en", 32'(o_cdb_en), 32'd0);
        t0 = next_tag;
        next_tag += 6'd4;
        // Full queue before the flush
        for (int i = 0; i < 4; i++) begin
            do_store(3'd2, 32'hc0 + 4 * i, rand_bits(32), t0 + 6'(i));
        end
        check("o_fu_stall", 32'(o_fu_stall), 32'd1);
        i_flush = 1'b1;
        @(negedge clk);
        i_flush = 1'b0;
        check("o_fu_stall", 32'(o_fu_stall), 32'd0);
        retire_absent(t0);
        do_load(3'd2, 32'hc0);
        do_load(3'd2, 32'hc4);
        finish_test("flush", e0);
    endtask

    initial begin
        n_rst            = 1'b0;
        i_flush          = 1'b0;
        i_fu_valid       = 1'b0;
        i_fu_opcode      = lsu_pkg::OPCODE_LOAD;
        i_fu_insn        = '0;
        i_fu_src_a       = '0;
        i_fu_src_b       = '0;
        i_fu_tag         = '0;
        i_rob_retire_en  = 1'b0;
        i_rob_retire_tag = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = 8'h00;
        end
        repeat (2) @(negedge clk);
        n_rst = 1'b1;
        @(negedge clk);
        test_reset();
        test_isolation();
        test_widths();
        test_back_pressure();
        test_flush();
        $display("Tests: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_if.sv
verilog/lsu_id.sv
verilog/lsu_ex.sv
verilog/lsu_sq_entry.sv
verilog/lsu_sq.sv
verilog/lsu_dc_ram.sv
verilog/lsu.sv
verification/lsu_sva.sv
verification/lsu_tb.sv

/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - include
    files:
      - verilog/lsu_pkg.sv
      - verilog/lsu_if.sv
      - verilog/lsu_id.sv
      - verilog/lsu_ex.sv
      - verilog/lsu_sq_entry.sv
      - verilog/lsu_sq.sv
      - verilog/lsu_dc_ram.sv
      - verilog/lsu.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/lsu_sva.sv
      - verification/lsu_tb.sv
